//--- source/cpu_pkg.sv
package cpu_pkg;

    localparam int word_w    = 16;
    localparam int reg_idx_w = 3;
    localparam int num_regs  = 1 << reg_idx_w;
    localparam int flags_w   = 5; // bit 4 reserved, reads zero

    typedef enum logic [6:0] {
        nop = 7'd0,
        mov = 7'd1,
        ldd = 7'd2,
        ldo = 7'd3,
        ldi = 7'd4,
        std = 7'd5,
        sto = 7'd6,
        add = 7'd7,
        adi = 7'd8,
        adc = 7'd9,
        sub = 7'd10,
        suc = 7'd11,
        cmp = 7'd12,
        cmi = 7'd13,
        jmp = 7'd14
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add    = 4'b0000,
        alu_sub    = 4'b0001,
        alu_pass_l = 4'b1001,
        alu_pass_r = 4'b1010
    } alu_mode_e;

    // condition field, instr[10:7]
    typedef enum logic [3:0] {
        jal = 4'd0,
        jca = 4'd1,
        jeq = 4'd2,
        jlt = 4'd3,
        jgt = 4'd4,
        jle = 4'd5,
        jge = 4'd6,
        jne = 4'd7,
        jvs = 4'd8 // 9 decodes the same
    } jump_cond_e;

    localparam int flag_eq = 0;
    localparam int flag_ca = 1;
    localparam int flag_lt = 2;
    localparam int flag_ov = 3;

endpackage

//--- source/queue_if.sv
`timescale 1ns/1ps

interface queue_if;
    import cpu_pkg::*;

    logic [word_w-1:0] head_word;
    logic [word_w-1:0] next_word;
    logic              head_valid;
    logic              next_valid;
    logic              pop_one;
    logic              pop_two;

    modport buffer (
        output head_word,
        output next_word,
        output head_valid,
        output next_valid,
        input  pop_one,
        input  pop_two
    );

    modport core (
        input  head_word,
        input  next_word,
        input  head_valid,
        input  next_valid,
        output pop_one,
        output pop_two
    );

endinterface

//--- source/instr_fetch.sv
`timescale 1ns/1ps

module instr_fetch #(
    parameter int IMEM_AW = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       space_ok,
    input  logic                       redirect,
    input  logic [IMEM_AW-1:0]         target,
    output logic                       imem_en,
    output logic [IMEM_AW-1:0]         imem_addr,
    input  logic [cpu_pkg::word_w-1:0] imem_data,
    output logic                       push_valid,
    output logic [cpu_pkg::word_w-1:0] push_word
);

    logic [IMEM_AW-1:0] pc;
    logic               in_flight;

    assign imem_en    = space_ok & ~redirect; // no request in the redirect cycle
    assign imem_addr  = pc;
    assign push_valid = in_flight & ~redirect; // drop word from the old path
    assign push_word  = imem_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            in_flight <= 1'b0;
        end else begin
            in_flight <= imem_en;
            if (redirect) begin
                pc <= target;
            end else if (imem_en) begin
                pc <= pc + 1'b1;
            end
        end
    end

endmodule

//--- source/instr_queue.sv
`timescale 1ns/1ps

module instr_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push_valid,
    input  logic [cpu_pkg::word_w-1:0] push_word,
    output logic                       space_ok,
    input  logic                       flush,
    queue_if.buffer                    q
);
    import cpu_pkg::*;

    localparam int ptr_w = $clog2(QUEUE_DEPTH);

    logic [word_w-1:0] mem [QUEUE_DEPTH];
    logic [ptr_w-1:0]  rd_ptr;
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  nxt_ptr;
    logic [ptr_w:0]    count;
    logic [ptr_w:0]    count_next;
    logic [1:0]        pop_n;
    logic              push;

    assign push    = push_valid & ~flush;
    assign pop_n   = q.pop_two ? 2'd2 : {1'b0, q.pop_one};
    assign nxt_ptr = rd_ptr + 1'b1;

    assign count_next = flush ? '0 :
        count + {{ptr_w{1'b0}}, push} - {{(ptr_w - 1){1'b0}}, pop_n};

    assign q.head_word  = mem[rd_ptr];
    assign q.next_word  = mem[nxt_ptr];
    assign q.head_valid = (count != '0);
    assign q.next_valid = (count > 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            space_ok <= 1'b0;
        end else begin
            count    <= count_next;
            space_ok <= (count_next <= QUEUE_DEPTH - 2); // room for one in flight
            if (flush) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + {{(ptr_w - 2){1'b0}}, pop_n};
                if (push) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        push |-> count < QUEUE_DEPTH
    );

    a_no_overpop: assert property (
        @(posedge clk) disable iff (rst)
        (q.pop_one |-> count >= 1) and (q.pop_two |-> count >= 2)
    );

endmodule

//--- source/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic [cpu_pkg::word_w-1:0]    instr,
    input  logic                          mem_busy,
    input  logic                          mem_ready,
    input  logic [cpu_pkg::flags_w-1:0]   flags,
    output logic                          pc_inc,
    output logic                          pc_ie,
    output logic                          reg_in_mux_ctl,
    output logic                          alu_r_mux_ctl,
    output logic                          alu_cin,
    output logic                          ram_write,
    output logic                          ram_read,
    output logic                          alu_flags_ie,
    output cpu_pkg::alu_mode_e            alu_mode,
    output logic [cpu_pkg::reg_idx_w-1:0] reg_l_ctl,
    output logic [cpu_pkg::reg_idx_w-1:0] reg_r_ctl,
    output logic [cpu_pkg::num_regs-1:0]  gp_reg_ie
);
    import cpu_pkg::*;

    opcode_e              op;
    logic [reg_idx_w-1:0] tg_reg;
    logic [reg_idx_w-1:0] fo_reg;
    logic [reg_idx_w-1:0] so_reg;
    logic [3:0]           cond;
    logic                 jmp_en;

    assign op     = opcode_e'(instr[6:0]);
    assign tg_reg = instr[9:7];
    assign fo_reg = instr[12:10];
    assign so_reg = instr[15:13];
    assign cond   = instr[10:7];

    always_comb begin
        pc_inc         = 1'b1;
        pc_ie          = 1'b0;
        reg_in_mux_ctl = 1'b0;
        alu_r_mux_ctl  = 1'b0;
        alu_cin        = 1'b0;
        ram_write      = 1'b0;
        ram_read       = 1'b0;
        alu_flags_ie   = 1'b0;
        alu_mode       = alu_add;
        reg_l_ctl      = '0;
        reg_r_ctl      = '0;
        gp_reg_ie      = '0;
        case (op)
            mov: begin
                alu_mode          = alu_pass_l;
                reg_l_ctl         = fo_reg;
                gp_reg_ie[tg_reg] = 1'b1;
            end
            ldd, ldo: begin
                alu_mode       = (op == ldd) ? alu_pass_r : alu_add; // address
                reg_l_ctl      = fo_reg;
                alu_r_mux_ctl  = 1'b1;
                reg_in_mux_ctl = 1'b1;
                if (mem_busy) begin
                    pc_inc = 1'b0;
                end else if (mem_ready) begin
                    gp_reg_ie[tg_reg] = 1'b1; // read data back
                end else begin
                    ram_read = 1'b1;
                    pc_inc   = 1'b0;
                end
            end
            ldi: begin
                alu_mode          = alu_pass_r;
                alu_r_mux_ctl     = 1'b1;
                gp_reg_ie[tg_reg] = 1'b1;
            end
            std, sto: begin
                alu_mode      = (op == std) ? alu_pass_r : alu_add;
                alu_r_mux_ctl = 1'b1;
                reg_r_ctl     = fo_reg; // store data
                reg_l_ctl     = so_reg;
                if (mem_busy) begin
                    pc_inc = 1'b0;
                end else begin
                    ram_write = 1'b1;
                end
            end
            add, adc, sub, suc: begin
                alu_mode          = (op == add || op == adc) ? alu_add : alu_sub;
                alu_cin           = (op == adc || op == suc) ? flags[flag_ca] : 1'b0;
                reg_l_ctl         = fo_reg;
                reg_r_ctl         = so_reg;
                gp_reg_ie[tg_reg] = 1'b1;
                alu_flags_ie      = 1'b1;
            end
            adi: begin
                reg_l_ctl         = fo_reg;
                alu_r_mux_ctl     = 1'b1;
                gp_reg_ie[tg_reg] = 1'b1;
                alu_flags_ie      = 1'b1;
            end
            cmp, cmi: begin
                alu_mode      = alu_sub;
                reg_l_ctl     = fo_reg;
                reg_r_ctl     = so_reg;
                alu_r_mux_ctl = (op == cmi);
                alu_flags_ie  = 1'b1;
            end
            jmp: begin
                alu_mode      = alu_pass_r; // target is the immediate
                alu_r_mux_ctl = 1'b1;
                pc_ie         = jmp_en;
                pc_inc        = ~jmp_en;
            end
            default: begin
                pc_inc = 1'b1; // nop and unused codes
            end
        endcase
    end

    always_comb begin
        case (cond)
            jca:     jmp_en = flags[flag_ca];
            jeq:     jmp_en = flags[flag_eq];
            jlt:     jmp_en = flags[flag_lt];
            jgt:     jmp_en = ~(flags[flag_lt] | flags[flag_eq]);
            jle:     jmp_en = flags[flag_lt] | flags[flag_eq];
            jge:     jmp_en = ~flags[flag_lt];
            jne:     jmp_en = ~flags[flag_eq];
            jvs,
            4'd9:    jmp_en = flags[flag_ov];
            default: jmp_en = 1'b1; // jal
        endcase
    end

endmodule

//--- source/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [cpu_pkg::word_w-1:0] a,
    input  logic [cpu_pkg::word_w-1:0] b,
    input  logic                       cin,
    input  cpu_pkg::alu_mode_e         mode,
    output logic [cpu_pkg::word_w-1:0] result,
    output logic [3:0]                 flags_out
);
    import cpu_pkg::*;

    localparam int msb = word_w - 1;

    logic [word_w:0] sum;
    logic            ov;

    always_comb begin
        ov = 1'b0;
        case (mode)
            alu_add: begin
                sum = {1'b0, a} + {1'b0, b} + cin;
                ov  = (a[msb] == b[msb]) && (sum[msb] != a[msb]);
            end
            alu_sub: begin
                sum = {1'b0, a} - {1'b0, b} - cin; // top bit is borrow
                ov  = (a[msb] != b[msb]) && (sum[msb] != a[msb]);
            end
            alu_pass_l: sum = {1'b0, a};
            alu_pass_r: sum = {1'b0, b};
            default:    sum = {1'b0, a};
        endcase
    end

    assign result = sum[msb:0];

    assign flags_out[flag_eq] = (result == '0);
    assign flags_out[flag_ca] = sum[word_w];
    assign flags_out[flag_lt] = result[msb];
    assign flags_out[flag_ov] = ov;

endmodule

//--- source/execute_core.sv
`timescale 1ns/1ps

module execute_core #(
    parameter int IMEM_AW = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    queue_if.core                      q,
    output logic                       redirect,
    output logic [IMEM_AW-1:0]         target,
    output logic [cpu_pkg::word_w-1:0] paddr,
    output logic                       psel,
    output logic                       penable,
    output logic                       pwrite,
    output logic [cpu_pkg::word_w-1:0] pwdata,
    input  logic [cpu_pkg::word_w-1:0] prdata,
    input  logic                       pready
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {
        ph_idle,
        ph_setup,
        ph_access
    } apb_phase_e;

    apb_phase_e           phase;
    logic [word_w-1:0]    regs [num_regs];
    logic [flags_w-1:0]   flags;
    logic [word_w-1:0]    ld_data;
    logic                 ld_ready;

    logic                 pc_inc;
    logic                 pc_ie;
    logic                 reg_in_mux_ctl;
    logic                 alu_r_mux_ctl;
    logic                 alu_cin;
    logic                 ram_write;
    logic                 ram_read;
    logic                 alu_flags_ie;
    alu_mode_e            alu_mode;
    logic [reg_idx_w-1:0] reg_l_ctl;
    logic [reg_idx_w-1:0] reg_r_ctl;
    logic [num_regs-1:0]  gp_reg_ie;

    logic [word_w-1:0]    alu_r;
    logic [word_w-1:0]    alu_res;
    logic [3:0]           alu_flags;
    logic [word_w-1:0]    wr_data;
    logic                 mem_busy;
    logic                 mem_ready;
    logic                 words_ok;
    logic                 retire;
    logic                 start;

    decoder u_decoder (
        .instr          (q.head_word),
        .mem_busy       (mem_busy),
        .mem_ready      (mem_ready),
        .flags          (flags),
        .pc_inc         (pc_inc),
        .pc_ie          (pc_ie),
        .reg_in_mux_ctl (reg_in_mux_ctl),
        .alu_r_mux_ctl  (alu_r_mux_ctl),
        .alu_cin        (alu_cin),
        .ram_write      (ram_write),
        .ram_read       (ram_read),
        .alu_flags_ie   (alu_flags_ie),
        .alu_mode       (alu_mode),
        .reg_l_ctl      (reg_l_ctl),
        .reg_r_ctl      (reg_r_ctl),
        .gp_reg_ie      (gp_reg_ie)
    );

    assign alu_r = alu_r_mux_ctl ? q.next_word : regs[reg_r_ctl]; // immediate mux

    alu u_alu (
        .a         (regs[reg_l_ctl]),
        .b         (alu_r),
        .cin       (alu_cin),
        .mode      (alu_mode),
        .result    (alu_res),
        .flags_out (alu_flags)
    );

    // immediate forms need the second word too
    assign words_ok  = q.head_valid & (~alu_r_mux_ctl | q.next_valid);
    assign retire    = words_ok & pc_inc;
    assign q.pop_one = retire & ~alu_r_mux_ctl;
    assign q.pop_two = retire & alu_r_mux_ctl;
    assign redirect  = words_ok & pc_ie;
    assign target    = alu_res[IMEM_AW-1:0];
    assign wr_data   = reg_in_mux_ctl ? ld_data : alu_res;

    assign mem_busy  = (phase != ph_idle);
    assign mem_ready = ld_ready;
    assign start     = words_ok & (ram_read | ram_write);
    assign psel      = (phase != ph_idle);
    assign penable   = (phase == ph_access);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
            flags <= '0;
        end else if (retire) begin
            for (int i = 0; i < num_regs; i++) begin
                if (gp_reg_ie[i]) begin
                    regs[i] <= wr_data;
                end
            end
            if (alu_flags_ie) begin
                flags <= {1'b0, alu_flags};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase    <= ph_idle;
            pwrite   <= 1'b0;
            ld_ready <= 1'b0;
        end else begin
            ld_ready <= 1'b0;
            case (phase)
                ph_idle: begin
                    if (start) begin
                        phase  <= ph_setup;
                        pwrite <= ram_write;
                    end
                end
                ph_setup: phase <= ph_access;
                ph_access: begin
                    if (pready) begin
                        phase    <= ph_idle;
                        ld_ready <= ~pwrite; // load retires next cycle
                    end
                end
                default: phase <= ph_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && phase == ph_idle) begin
            paddr  <= alu_res;
            pwdata <= regs[reg_r_ctl];
        end
        if (penable && pready && !pwrite) begin
            ld_data <= prdata;
        end
    end

endmodule

//--- source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter int QUEUE_DEPTH = 8,
    parameter int IMEM_AW     = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    output logic                       imem_en,
    output logic [IMEM_AW-1:0]         imem_addr,
    input  logic [cpu_pkg::word_w-1:0] imem_data,
    output logic [cpu_pkg::word_w-1:0] paddr,
    output logic                       psel,
    output logic                       penable,
    output logic                       pwrite,
    output logic [cpu_pkg::word_w-1:0] pwdata,
    input  logic [cpu_pkg::word_w-1:0] prdata,
    input  logic                       pready
);
    import cpu_pkg::*;

    logic               push_valid;
    logic [word_w-1:0]  push_word;
    logic               space_ok;
    logic               redirect;
    logic [IMEM_AW-1:0] target;

    queue_if q_bus ();

    instr_fetch #(
        .IMEM_AW (IMEM_AW)
    ) u_fetch (
        .clk        (clk),
        .rst        (rst),
        .space_ok   (space_ok),
        .redirect   (redirect),
        .target     (target),
        .imem_en    (imem_en),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .push_valid (push_valid),
        .push_word  (push_word)
    );

    instr_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk        (clk),
        .rst        (rst),
        .push_valid (push_valid),
        .push_word  (push_word),
        .space_ok   (space_ok),
        .flush      (redirect),
        .q          (q_bus.buffer)
    );

    execute_core #(
        .IMEM_AW (IMEM_AW)
    ) u_core (
        .clk      (clk),
        .rst      (rst),
        .q        (q_bus.core),
        .redirect (redirect),
        .target   (target),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready)
    );

endmodule

//--- bench/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

typedef struct packed {
    logic        write;
    logic [15:0] addr;
    logic [15:0] data;
} apb_txn_t;

logic [15:0] m_prog [256];
logic [15:0] m_ram  [256];
logic [15:0] m_regs [8];
logic [4:0]  m_flags;
logic [7:0]  m_pc;
apb_txn_t    exp_log [$]; // expected transfers in program order

task automatic model_reset();
    for (int i = 0; i < 8; i++) begin
        m_regs[i] = 16'h0000;
    end
    m_flags = 5'b00000;
    m_pc    = 8'h00;
endtask

function automatic logic uses_imm(input logic [6:0] op);
    return op inside {ldd, ldo, ldi, std, sto, adi, cmi, jmp};
endfunction

// add or subtract with carry in, flags as {ov, lt, ca, eq}
function automatic logic [15:0] model_arith(input logic [15:0] a, input logic [15:0] b,
                                            input logic cin, input logic subtract,
                                            output logic [3:0] fl);
    int          ua;
    int          ub;
    int          sa;
    int          sb;
    int          u_res;
    int          s_res;
    logic [15:0] res;
    ua = a;
    ub = b;
    sa = $signed(a);
    sb = $signed(b);
    if (subtract) begin
        u_res = ua - ub - cin;
        s_res = sa - sb - cin;
    end else begin
        u_res = ua + ub + cin;
        s_res = sa + sb + cin;
    end
    res       = u_res[15:0];
    fl[0]     = (res == 16'h0000);
    fl[1]     = subtract ? (u_res < 0) : (u_res > 65535); // borrow on subtract
    fl[2]     = res[15];
    fl[3]     = (s_res > 32767) || (s_res < -32768);
    return res;
endfunction

function automatic logic cond_true(input logic [3:0] c, input logic [4:0] f);
    case (c)
        jca:       return f[1];
        jeq:       return f[0];
        jlt:       return f[2];
        jgt:       return !(f[2] || f[0]);
        jle:       return f[2] || f[0];
        jge:       return !f[2];
        jne:       return !f[0];
        jvs, 4'd9: return f[3];
        default:   return 1'b1;
    endcase
endfunction

task automatic log_access(input logic wr, input logic [15:0] a, input logic [15:0] d);
    apb_txn_t t;
    t.write = wr;
    t.addr  = a;
    t.data  = d;
    exp_log.push_back(t);
endtask

// run the program until the next data memory access
task automatic model_run_until_access();
    logic [15:0] ins;
    logic [15:0] imm;
    logic [15:0] res;
    logic [7:0]  nxt;
    logic [6:0]  op;
    logic [2:0]  tg;
    logic [2:0]  fo;
    logic [2:0]  so;
    logic [3:0]  fl;
    logic        done;
    int          steps;
    done  = 1'b0;
    steps = 0;
    while (!done) begin
        ins = m_prog[m_pc];
        nxt = m_pc + 8'd1;
        imm = m_prog[nxt];
        op  = ins[6:0];
        tg  = ins[9:7];
        fo  = ins[12:10];
        so  = ins[15:13];
        case (op)
            mov: m_regs[tg] = m_regs[fo];
            ldi: m_regs[tg] = imm;
            ldd, ldo: begin
                res = (op == ldd) ? imm : m_regs[fo] + imm;
                log_access(1'b0, res, m_ram[res[7:0]]);
                m_regs[tg] = m_ram[res[7:0]];
                done = 1'b1;
            end
            std, sto: begin
                res = (op == std) ? imm : m_regs[so] + imm;
                log_access(1'b1, res, m_regs[fo]);
                m_ram[res[7:0]] = m_regs[fo];
                done = 1'b1;
            end
            add, adc, sub, suc: begin
                m_regs[tg] = model_arith(m_regs[fo], m_regs[so],
                    (op == adc || op == suc) && m_flags[1], (op == sub || op == suc), fl);
                m_flags = {1'b0, fl};
            end
            adi: begin
                m_regs[tg] = model_arith(m_regs[fo], imm, 1'b0, 1'b0, fl);
                m_flags    = {1'b0, fl};
            end
            cmp, cmi: begin
                res     = model_arith(m_regs[fo], (op == cmi) ? imm : m_regs[so], 1'b0,
                                      1'b1, fl);
                m_flags = {1'b0, fl};
            end
            default: ; // nop and unused codes
        endcase
        if (op == jmp && cond_true(ins[10:7], m_flags)) begin
            m_pc = imm[7:0];
        end else begin
            m_pc = m_pc + (uses_imm(op) ? 8'd2 : 8'd1);
        end
        steps++;
        if (steps > 4096) begin
            stop_with_error("model ran 4096 instructions without a memory access");
        end
    end
endtask

`endif

//--- bench/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    localparam int num_txn  = 300;
    localparam int wait_max = 3000; // cycles allowed per transfer

    logic        clk;
    logic        rst;
    logic        imem_en;
    logic [7:0]  imem_addr;
    logic [15:0] imem_data;
    logic [15:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] pwdata;
    logic [15:0] prdata;
    logic        pready;

    integer      seed;
    logic [15:0] prog_mem [256];
    logic [15:0] tb_ram   [256];
    int          wait_left;
    int          txn_count;
    logic        prev_psel;
    logic        prev_penable;

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic fail_value(input string msg);
        stop_with_error($sformatf("FAIL t=%0t %s", $time, msg));
    endtask

    `include "cpu_model.svh"

    cpu_top #(
        .QUEUE_DEPTH (8),
        .IMEM_AW     (8)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .imem_en   (imem_en),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready)
    );

    always #10 clk = ~clk;

    function automatic logic [7:0] pick_imm();
        logic [7:0] v;
        v = $random(seed);
        if (v[6:0] == 7'd14) begin
            v[0] = 1'b1; // keep immediates from decoding as jmp
        end
        return v;
    endfunction

    // forward targets only, so every path reaches the wrap at 255
    function automatic logic [7:0] pick_target(input int unsigned p);
        int unsigned r;
        logic [7:0]  t;
        r = $random(seed);
        t = p + 2 + r % (254 - p);
        if (t[6:0] == 7'd14) begin
            t[0] = 1'b1;
        end
        return t;
    endfunction

    task automatic build_program();
        int unsigned r;
        int unsigned p;
        logic [6:0]  op;
        for (int i = 0; i < 256; i++) begin
            prog_mem[i] = 16'h0000;
            tb_ram[i]   = $random(seed);
            m_ram[i]    = tb_ram[i];
        end
        r           = $random(seed);
        prog_mem[0] = {r[15:7], 7'd5}; // std opens every lap
        prog_mem[1] = {8'h00, pick_imm()};
        p           = 2;
        while (p < 248) begin // 248..255 stay nop
            r  = $random(seed);
            op = (r % 20 < 6) ? 7'd0 : 7'(1 + (r / 20) % 14);
            if (uses_imm(op) && p >= 247) begin
                op = 7'd0;
            end
            r           = $random(seed);
            prog_mem[p] = {r[15:7], op};
            if (uses_imm(op)) begin
                prog_mem[p + 1] = {8'h00, (op == jmp) ? pick_target(p) : pick_imm()};
                p += 2;
            end else begin
                p += 1;
            end
        end
        for (int i = 0; i < 256; i++) begin
            m_prog[i] = prog_mem[i];
        end
    endtask

    always @(posedge clk) begin
        if (imem_en) begin
            imem_data <= prog_mem[imem_addr];
        end
    end

    // APB slave with 0 to 3 wait states
    always @(posedge clk) begin : apb_slave
        int w;
        if (rst) begin
            pready    <= 1'b0;
            wait_left <= 0;
        end else if (psel && !penable) begin
            w          = $unsigned($random(seed)) % 4;
            wait_left <= w;
            pready    <= (w == 0);
            prdata    <= tb_ram[paddr[7:0]];
        end else if (psel && penable) begin
            if (pready) begin
                pready <= 1'b0;
                if (pwrite) begin
                    tb_ram[paddr[7:0]] <= pwdata;
                end
            end else begin
                pready    <= (wait_left == 1);
                wait_left <= wait_left - 1;
            end
        end
    end

    always @(posedge clk) begin : monitor
        apb_txn_t want;
        if (!rst) begin
            assert (!$isunknown({psel, penable, imem_en}))
            else stop_with_error("psel, penable or imem_en went unknown after reset");
            assert (psel || !penable)
            else stop_with_error("penable high without psel");
            if (imem_en) begin
                assert (!$isunknown(imem_addr))
                else stop_with_error("imem_addr unknown during a fetch request");
            end
            if (psel) begin
                assert (!$isunknown({paddr, pwrite}))
                else stop_with_error("paddr or pwrite unknown while psel is high");
            end
            if (penable && !prev_penable) begin
                assert (prev_psel)
                else stop_with_error("penable rose without a setup phase");
            end
            if (prev_psel && !prev_penable) begin
                assert (psel && penable)
                else stop_with_error("setup phase not followed by an access phase");
            end
            if (psel && penable && pready) begin
                if (exp_log.size() == 0) begin
                    model_run_until_access();
                end
                want = exp_log.pop_front();
                assert (pwrite == want.write)
                else fail_value($sformatf("txn %0d pwrite %0b expected %0b",
                                          txn_count, pwrite, want.write));
                assert (paddr == want.addr)
                else fail_value($sformatf("txn %0d paddr %h expected %h",
                                          txn_count, paddr, want.addr));
                if (want.write) begin
                    assert (pwdata == want.data)
                    else fail_value($sformatf("txn %0d pwdata %h expected %h",
                                              txn_count, pwdata, want.data));
                end
                txn_count <= txn_count + 1;
            end
        end
        prev_psel    <= rst ? 1'b0 : psel;
        prev_penable <= rst ? 1'b0 : penable;
    end

    task automatic wait_for_transaction();
        int start_count;
        int cycles;
        start_count = txn_count;
        cycles      = 0;
        while (txn_count == start_count) begin
            @(posedge clk);
            cycles++;
            if (cycles > wait_max) begin
                stop_with_error($sformatf("timeout, no APB transfer completed in %0d cycles",
                                          wait_max));
            end
        end
    endtask

    initial begin
        seed         = 67;
        clk          = 1'b0;
        rst          = 1'b1;
        imem_data    = 16'h0000;
        prdata       = 16'h0000;
        pready       = 1'b0;
        wait_left    = 0;
        txn_count    = 0;
        prev_psel    = 1'b0;
        prev_penable = 1'b0;
        model_reset();
        build_program();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        while (txn_count < num_txn) begin
            wait_for_transaction();
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- sim.f
+incdir+bench
source/cpu_pkg.sv
source/queue_if.sv
source/instr_fetch.sv
source/instr_queue.sv
source/decoder.sv
source/alu.sv
source/execute_core.sv
source/cpu_top.sv
bench/tb_cpu.sv
